//--- logic/calib_defines.svh
/*
 * pfd offset calibration widths
 * shared sizing for samples, bin fields, counters and the offset
 */

`ifndef CALIB_DEFINES_SVH
`define CALIB_DEFINES_SVH

// adc sample width, signed two's complement
`define CALIB_NADC 8

// bin half-width and dead-zone field width
`define CALIB_NRANGE 4

// histogram counters, 2**CALIB_NRANGE bits
`define CALIB_CNT_W 16

// offset estimate, unsigned
`define CALIB_OFFSET_W 10

`endif

//--- logic/calib_pkg.sv
/*
 * pfd offset calibration types
 * configuration, histogram result and status words
 */

`include "calib_defines.svh"

package calib_pkg;

    // static configuration from the top-level ports, 38 bits
    typedef struct packed {
        logic [`CALIB_NRANGE-1:0]   nbin;
        // dead zone is 2**dz
        logic [`CALIB_NRANGE-1:0]   dz;
        logic                       flip_feedback;
        // window is 2**win_log2 samples, 2..15
        logic [3:0]                 win_log2;
        logic [4:0]                 step;
        logic [`CALIB_OFFSET_W-1:0] offset_max;
        // not decoded
        logic [9:0]                 reserved;
    } calib_cfg_t;

    // per-window histogram outcome
    typedef struct packed {
        logic [`CALIB_CNT_W-1:0] center;
        logic [`CALIB_CNT_W-1:0] side;
        // +1 up, 0 hold, -1 down
        logic signed [1:0]       comp;
    } hist_result_t;

    // published calibration state
    typedef struct packed {
        logic [`CALIB_OFFSET_W-1:0]      pfd_offset;
        logic signed [`CALIB_NADC-1:0]   din_avg;
        logic signed [1:0]               last_comp;
    } calib_status_t;

endpackage

//--- logic/calib_mean_track.sv
/*
 * mean tracker
 * averages the signed sample stream over 2**win_log2 samples, issues the window strobe
 */

`timescale 1ns/1ps

`include "calib_defines.svh"

module calib_mean_track
    import calib_pkg::*;
(
    input  logic                          clk,
    input  logic                          rstb,
    input  logic signed [`CALIB_NADC-1:0] din,
    input  calib_cfg_t                    cfg,
    output logic                          update,
    output logic signed [`CALIB_NADC-1:0] din_avg
);

    // window counter covers up to 2**15 samples
    localparam int WIN_W = 15;
    localparam int LEN_W = WIN_W + 1;
    // sample width plus window growth
    localparam int ACC_W = `CALIB_NADC + WIN_W;

    //////////////////////////////////////////////////////////////////////
    // window counter
    //////////////////////////////////////////////////////////////////////

    logic [LEN_W-1:0] win_len;
    logic [WIN_W-1:0] win_last;
    logic [WIN_W-1:0] win_cnt;

    // one extra bit so 2**15 itself is representable
    assign win_len  = LEN_W'(1) << cfg.win_log2;
    assign win_last = WIN_W'(win_len - LEN_W'(1));

    // strobe on the last sample of the window
    assign update = (win_cnt == win_last);

    always_ff @(posedge clk or negedge rstb) begin
        if (!rstb) begin
            win_cnt <= '0;
        end else if (update) begin
            win_cnt <= '0;
        end else begin
            win_cnt <= win_cnt + WIN_W'(1);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // accumulator and mean
    //////////////////////////////////////////////////////////////////////

    logic signed [ACC_W-1:0] acc;
    logic signed [ACC_W-1:0] sum_next;
    logic signed [ACC_W-1:0] avg_full;

    // running sum including the current sample
    assign sum_next = acc + ACC_W'(din);

    // arithmetic shift, floors toward minus infinity
    assign avg_full = sum_next >>> cfg.win_log2;

    always_ff @(posedge clk or negedge rstb) begin
        if (!rstb) begin
            acc     <= '0;
            din_avg <= '0;
        end else if (update) begin
            // next window starts from the following sample
            acc     <= '0;
            din_avg <= avg_full[`CALIB_NADC-1:0];
        end else begin
            acc     <= sum_next;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    // windows are at least 4 samples, strobe is a single pulse
    update_single_cycle: assert property (
        @(posedge clk) disable iff (!rstb)
        update |=> !update
    ) else $error("update held high for two cycles");

endmodule

//--- logic/calib_hist_measure.sv
/*
 * histogram measure
 * counts centre and side bin hits around the previous mean, decides up, down or hold
 */

`timescale 1ns/1ps

`include "calib_defines.svh"

module calib_hist_measure
    import calib_pkg::*;
(
    input  logic                          clk,
    input  logic                          rstb,
    input  logic                          update,
    input  logic signed [`CALIB_NADC-1:0] din,
    input  logic signed [`CALIB_NADC-1:0] din_avg,
    input  calib_cfg_t                    cfg,
    output hist_result_t                  result
);

    // two guard bits, mean +- (3*15+2) stays in range
    localparam int TH_W   = `CALIB_NADC + 2;
    localparam int CNT_W  = `CALIB_CNT_W;
    localparam int DIFF_W = CNT_W + 1;

    localparam logic signed [TH_W-1:0] TH_ONE = 1;
    localparam logic signed [TH_W-1:0] TH_TWO = 2;

    // decision codes
    localparam logic signed [1:0] COMP_POS = 2'sb01;
    localparam logic signed [1:0] COMP_NEG = 2'sb11;

    //////////////////////////////////////////////////////////////////////
    // thresholds
    //////////////////////////////////////////////////////////////////////

    logic signed [TH_W-1:0] din_w;
    logic signed [TH_W-1:0] avg_w;
    logic signed [TH_W-1:0] nbin_w;
    logic signed [TH_W-1:0] nbin3_w;
    logic signed [TH_W-1:0] th_l2;
    logic signed [TH_W-1:0] th_l1;
    logic signed [TH_W-1:0] th_r1;
    logic signed [TH_W-1:0] th_r2;

    // sign-extend samples, zero-extend the bin size
    assign din_w   = TH_W'(din);
    assign avg_w   = TH_W'(din_avg);
    assign nbin_w  = $signed(TH_W'(cfg.nbin));
    assign nbin3_w = nbin_w + (nbin_w <<< 1);

    // outer edges
    assign th_l2 = avg_w - nbin3_w - TH_TWO;
    assign th_r2 = avg_w + nbin3_w + TH_TWO;
    // inner edges
    assign th_l1 = avg_w - nbin_w - TH_ONE;
    assign th_r1 = avg_w + nbin_w + TH_ONE;

    //////////////////////////////////////////////////////////////////////
    // bin classification and counters
    //////////////////////////////////////////////////////////////////////

    // index 0 left, 1 centre, 2 right
    logic [2:0]       hit;
    logic [CNT_W-1:0] cnt [3];

    assign hit[0] = (th_l2 < din_w) && (din_w <= th_l1);
    assign hit[1] = (th_l1 < din_w) && (din_w < th_r1);
    assign hit[2] = (th_r1 <= din_w) && (din_w < th_r2);

    always_ff @(posedge clk or negedge rstb) begin
        if (!rstb) begin
            for (int i = 0; i < 3; i++) begin
                cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 3; i++) begin
                // window restart keeps this cycle's hit
                if (update) begin
                    cnt[i] <= CNT_W'(hit[i]);
                end else begin
                    cnt[i] <= cnt[i] + CNT_W'(hit[i]);
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // side average and difference
    //////////////////////////////////////////////////////////////////////

    logic [CNT_W:0]           side_sum;
    logic [CNT_W-1:0]         side_avg;
    logic signed [DIFF_W-1:0] hist_diff;
    logic signed [DIFF_W-1:0] dz_pos;
    logic signed [DIFF_W-1:0] dz_neg;

    // carry bit kept before halving
    assign side_sum  = {1'b0, cnt[0]} + {1'b0, cnt[2]};
    assign side_avg  = side_sum[CNT_W:1];
    assign hist_diff = $signed({1'b0, cnt[1]}) - $signed({1'b0, side_avg});

    // dead zone is +- 2**dz
    assign dz_pos = $signed(DIFF_W'(1) << cfg.dz);
    assign dz_neg = -dz_pos;

    //////////////////////////////////////////////////////////////////////
    // decision
    //////////////////////////////////////////////////////////////////////

    logic signed [1:0] comp_up;
    logic signed [1:0] comp_dn;

    assign comp_up = cfg.flip_feedback ? COMP_NEG : COMP_POS;
    assign comp_dn = cfg.flip_feedback ? COMP_POS : COMP_NEG;

    always_comb begin
        result.center = cnt[1];
        result.side   = side_avg;
        if ((cnt[1] == '0) && (side_avg == '0)) begin
            // nothing near the mean, offset too small
            result.comp = comp_up;
        end else if (hist_diff > dz_pos) begin
            // centre crowded
            result.comp = comp_dn;
        end else if (hist_diff < dz_neg) begin
            // sides dominate
            result.comp = comp_up;
        end else begin
            result.comp = 2'sb00;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    // bins are disjoint for any mean and nbin
    bins_disjoint: assert property (
        @(posedge clk) disable iff (!rstb)
        $onehot0(hit)
    ) else $error("more than one bin hit in a cycle");

endmodule

//--- logic/calib_offset_est.sv
/*
 * offset estimator
 * steps a saturating offset by the histogram decision at each window, publishes status
 */

`timescale 1ns/1ps

`include "calib_defines.svh"

module calib_offset_est
    import calib_pkg::*;
(
    input  logic                          clk,
    input  logic                          rstb,
    input  logic                          update,
    input  hist_result_t                  result,
    input  logic signed [`CALIB_NADC-1:0] din_avg,
    input  calib_cfg_t                    cfg,
    output calib_status_t                 status
);

    localparam int OFS_W = `CALIB_OFFSET_W;
    // one bit of headroom for the upward sum
    localparam int SUM_W = OFS_W + 1;

    //////////////////////////////////////////////////////////////////////
    // next offset
    //////////////////////////////////////////////////////////////////////

    calib_status_t    status_q;
    logic [SUM_W-1:0] ofs_w;
    logic [SUM_W-1:0] step_w;
    logic [SUM_W-1:0] max_w;
    logic [SUM_W-1:0] up_sum;
    logic [SUM_W-1:0] cand;
    logic [OFS_W-1:0] ofs_next;

    assign ofs_w  = {1'b0, status_q.pfd_offset};
    assign step_w = SUM_W'(cfg.step);
    assign max_w  = {1'b0, cfg.offset_max};
    assign up_sum = ofs_w + step_w;

    always_comb begin
        case (result.comp)
            // +1, move up
            2'b01: cand = up_sum;
            // -1, move down and floor at zero
            2'b11: cand = (ofs_w >= step_w) ? (ofs_w - step_w) : '0;
            default: cand = ofs_w;
        endcase
        // upper clamp, also catches a lowered offset_max
        if (cand > max_w) begin
            ofs_next = cfg.offset_max;
        end else begin
            ofs_next = cand[OFS_W-1:0];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // offset and status register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstb) begin
        if (!rstb) begin
            status_q <= '0;
        end else if (update) begin
            status_q.pfd_offset <= ofs_next;
            // mean that set this window's thresholds
            status_q.din_avg    <= din_avg;
            status_q.last_comp  <= result.comp;
        end
    end

    assign status = status_q;

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    // after a window boundary with steady cfg the offset is in range
    offset_in_range: assert property (
        @(posedge clk) disable iff (!rstb)
        ($past(update) && $stable(cfg)) |-> (status.pfd_offset <= cfg.offset_max)
    ) else $error("pfd_offset above offset_max");

endmodule

//--- logic/calib_pfd_offset_top.sv
/*
 * pfd offset calibration top
 * mean tracker and histogram measure side by side, offset estimator combines them
 */

`timescale 1ns/1ps

`include "calib_defines.svh"

module calib_pfd_offset_top
    import calib_pkg::*;
(
    input  logic                          clk,
    input  logic                          rstb,
    input  logic signed [`CALIB_NADC-1:0] din,
    input  calib_cfg_t                    cfg,
    output logic                          update,
    output calib_status_t                 status
);

    // window mean, valid from the cycle after update
    logic signed [`CALIB_NADC-1:0] din_avg;
    // bin counts and decision, complete during update
    hist_result_t                  hist_res;

    //////////////////////////////////////////////////////////////////////
    // parallel measurement
    //////////////////////////////////////////////////////////////////////

    calib_mean_track u_mean_track (
        .clk     (clk),
        .rstb    (rstb),
        .din     (din),
        .cfg     (cfg),
        .update  (update),
        .din_avg (din_avg)
    );

    calib_hist_measure u_hist_measure (
        .clk     (clk),
        .rstb    (rstb),
        .update  (update),
        .din     (din),
        .din_avg (din_avg),
        .cfg     (cfg),
        .result  (hist_res)
    );

    //////////////////////////////////////////////////////////////////////
    // offset integration
    //////////////////////////////////////////////////////////////////////

    calib_offset_est u_offset_est (
        .clk     (clk),
        .rstb    (rstb),
        .update  (update),
        .result  (hist_res),
        .din_avg (din_avg),
        .cfg     (cfg),
        .status  (status)
    );

endmodule

//--- tests/calib_tb.sv
/*
 * pfd offset calibration testbench
 * drives sample phases, replays the window rules in a model, checks with assertions
 */

`timescale 1ns/1ps

`include "calib_defines.svh"

module calib_tb
    import calib_pkg::*;
();

    localparam int WIN_LOG2 = 4;
    localparam int WIN_LEN  = 1 << WIN_LOG2;
    localparam int STEP     = 4;
    localparam int OFS_MAX  = 40;

    // stimulus modes
    localparam int M_CONST = 0;
    localparam int M_FAR   = 1;
    localparam int M_SPLIT = 2;
    localparam int M_RAND  = 3;

    logic                          clk = 1'b0;
    logic                          rstb;
    logic signed [`CALIB_NADC-1:0] din;
    calib_cfg_t                    cfg;
    logic                          update;
    calib_status_t                 status;

    integer seed;
    int     stim_mode;
    int     const_val;
    bit     phase_flip;
    int     sample_idx;

    calib_pfd_offset_top dut (
        .clk    (clk),
        .rstb   (rstb),
        .din    (din),
        .cfg    (cfg),
        .update (update),
        .status (status)
    );

    // 8 ns period
    always #4 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // failure reporting
    //////////////////////////////////////////////////////////////////////

    task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] exp);
        $display("error: %s is 0x%0h, expected 0x%0h", name, got, exp);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic abort_run(string what);
        $display("%s", what);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////

    int   m_cnt;
    int   m_sum;
    int   m_avg;
    int   m_left;
    int   m_cent;
    int   m_right;
    int   m_ofs;
    int   m_st_avg;
    int   m_st_comp;
    logic m_update;

    // up +1, down -1, hold 0
    function automatic int window_decision(int center, int side, int dz, bit flip);
        int up;
        int dead;
        up   = flip ? -1 : 1;
        dead = 1 << dz;
        if (center == 0 && side == 0) begin
            return up;
        end
        if (center - side > dead) begin
            return -up;
        end
        if (center - side < -dead) begin
            return up;
        end
        return 0;
    endfunction

    assign m_update = (m_cnt == (1 << cfg.win_log2) - 1);

    always @(posedge clk or negedge rstb) begin : model_step
        int d;
        int nb;
        int hl;
        int hc;
        int hr;
        int dec;
        int nofs;
        if (!rstb) begin
            m_cnt     <= 0;
            m_sum     <= 0;
            m_avg     <= 0;
            m_left    <= 0;
            m_cent    <= 0;
            m_right   <= 0;
            m_ofs     <= 0;
            m_st_avg  <= 0;
            m_st_comp <= 0;
        end else begin
            d  = int'(din);
            nb = int'(cfg.nbin);
            // bins around the mean of the previous window
            hc = (d > m_avg - nb - 1) && (d < m_avg + nb + 1);
            hl = (d > m_avg - 3 * nb - 2) && (d <= m_avg - nb - 1);
            hr = (d >= m_avg + nb + 1) && (d < m_avg + 3 * nb + 2);
            if (m_update) begin
                dec  = window_decision(m_cent, (m_left + m_right) / 2,
                                       int'(cfg.dz), cfg.flip_feedback);
                nofs = m_ofs + dec * int'(cfg.step);
                if (nofs > int'(cfg.offset_max)) begin
                    nofs = int'(cfg.offset_max);
                end
                if (nofs < 0) begin
                    nofs = 0;
                end
                m_ofs     <= nofs;
                m_st_avg  <= m_avg;
                m_st_comp <= dec;
                // floored mean of the finished window
                m_avg     <= (m_sum + d) >>> cfg.win_log2;
                m_sum     <= 0;
                m_cnt     <= 0;
                m_left    <= hl;
                m_cent    <= hc;
                m_right   <= hr;
            end else begin
                m_sum   <= m_sum + d;
                m_cnt   <= m_cnt + 1;
                m_left  <= m_left + hl;
                m_cent  <= m_cent + hc;
                m_right <= m_right + hr;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    update_vs_model: assert property (@(posedge clk) disable iff (!rstb) update == m_update)
        else report_mismatch("update", $sampled(update), $sampled(m_update));

    offset_vs_model: assert property (@(posedge clk) disable iff (!rstb)
        int'(status.pfd_offset) == m_ofs)
        else report_mismatch("pfd_offset", $sampled(status.pfd_offset), $sampled(m_ofs));

    avg_vs_model: assert property (@(posedge clk) disable iff (!rstb)
        int'(status.din_avg) == m_st_avg)
        else report_mismatch("din_avg", $sampled(status.din_avg), $sampled(m_st_avg));

    comp_vs_model: assert property (@(posedge clk) disable iff (!rstb)
        int'(status.last_comp) == m_st_comp)
        else report_mismatch("last_comp", $sampled(status.last_comp), $sampled(m_st_comp));

    // quiet outputs on the first cycle out of reset
    reset_state: assert property (@(posedge clk) $rose(rstb) |-> (!update && status == '0))
        else abort_run("update or status not cleared after reset");

    pulse_period: assert property (@(posedge clk) disable iff (!rstb)
        update |=> (!update) [*WIN_LEN-1] ##1 update)
        else abort_run("update pulses are not one window apart");

    offset_range: assert property (@(posedge clk) disable iff (!rstb)
        status.pfd_offset <= cfg.offset_max)
        else report_mismatch("pfd_offset", $sampled(status.pfd_offset),
                             $sampled(cfg.offset_max));

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    task automatic drive_sample();
        // phase config takes effect with the first sample of a window
        if (sample_idx == 0) begin
            cfg.flip_feedback = phase_flip;
        end
        case (stim_mode)
            M_CONST: din = `CALIB_NADC'(const_val);
            M_FAR:   din = (sample_idx % 2 == 1) ? -8'sd100 : 8'sd100;
            M_SPLIT: begin
                // centre, left, right, then an outlier
                case (sample_idx % 8)
                    0, 4:    din = 8'sd0;
                    1, 5:    din = -8'sd5;
                    2, 6:    din = 8'sd5;
                    3:       din = 8'sd60;
                    default: din = -8'sd60;
                endcase
            end
            default: begin
                // new bin size and dead zone per window
                if (sample_idx % WIN_LEN == 0) begin
                    cfg.nbin = `CALIB_NRANGE'($random(seed));
                    cfg.dz   = `CALIB_NRANGE'($random(seed) & 3);
                end
                din = `CALIB_NADC'($random(seed));
            end
        endcase
        sample_idx++;
    endtask

    task automatic step_cycle();
        @(posedge clk);
        #1;
        drive_sample();
    endtask

    task automatic begin_phase(int mode, int value, bit flip);
        stim_mode  = mode;
        const_val  = value;
        phase_flip = flip;
        sample_idx = 0;
    endtask

    // returns in the update cycle of the n-th window
    task automatic run_windows(int n);
        int done;
        int cycles;
        done   = 0;
        cycles = 0;
        while (done < n) begin
            if (cycles > n * WIN_LEN + WIN_LEN) begin
                abort_run("timed out waiting for an update pulse");
            end
            step_cycle();
            cycles++;
            if (update) begin
                done++;
            end
        end
    endtask

    task automatic expect_status(int ofs, int avg, int comp);
        assert (int'(status.pfd_offset) == ofs)
            else report_mismatch("pfd_offset", status.pfd_offset, ofs);
        assert (int'(status.din_avg) == avg)
            else report_mismatch("din_avg", status.din_avg, avg);
        assert (int'(status.last_comp) == comp)
            else report_mismatch("last_comp", status.last_comp, comp);
    endtask

    initial begin : main
        int cycles;
        seed = 24;
        rstb = 1'b0;
        din  = '0;
        cfg  = '{nbin: 4'd2, dz: 4'd1, flip_feedback: 1'b0, win_log2: 4'(WIN_LOG2),
                 step: 5'(STEP), offset_max: 10'(OFS_MAX), reserved: 10'h155};
        begin_phase(M_CONST, 20, 1'b0);
        repeat (8) @(posedge clk);
        #1;
        rstb = 1'b1;
        drive_sample();

        // first pulse within one window of release
        cycles = 0;
        while (!update) begin
            if (cycles >= WIN_LEN) begin
                abort_run("no update pulse within 16 cycles of reset release");
            end
            step_cycle();
            cycles++;
        end
        run_windows(2);

        // outside every bin the offset climbs to the clamp
        begin_phase(M_FAR, 0, 1'b0);
        step_cycle();
        expect_status(0, 20, -1);
        run_windows(13);

        // equal centre and side counts stay in the dead zone
        begin_phase(M_SPLIT, 0, 1'b0);
        step_cycle();
        expect_status(OFS_MAX, 0, 1);
        run_windows(3);

        // flipped feedback walks down
        begin_phase(M_FAR, 0, 1'b1);
        step_cycle();
        expect_status(OFS_MAX, 0, 0);
        run_windows(3);

        // crowded centre walks down to the floor
        begin_phase(M_CONST, 0, 1'b0);
        step_cycle();
        expect_status(OFS_MAX - 3 * STEP, 0, -1);
        run_windows(10);

        begin_phase(M_RAND, 0, 1'b0);
        step_cycle();
        expect_status(0, 0, -1);
        run_windows(40);
        // one more edge so the last status word is compared
        step_cycle();
        step_cycle();

        $display("TESTS PASSED");
        $finish;
    end

endmodule

//--- files.f
+incdir+logic
logic/calib_pkg.sv
logic/calib_mean_track.sv
logic/calib_hist_measure.sv
logic/calib_offset_est.sv
logic/calib_pfd_offset_top.sv
tests/calib_tb.sv
